//--- build.f
+incdir+design
design/cpu_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/hazard_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/mem_access.sv
design/pipeline_cpu.sv
dv/pipeline_cpu_checker.sv
dv/pipeline_cpu_tb.sv

//--- dv/pipeline_cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pipeline_cpu_tb;
    import cpu_pkg::*;

    localparam int          PROG_WORDS       = 32;
    localparam int          RESET_CYCLES     = 4;
    localparam int          CYCLES_PER_ENTRY = 60;
    localparam int          TAIL_CYCLES      = 40;
    localparam int unsigned SEED             = 32'hc09c5e7d;

    logic        clk;
    logic        rst_n;
    logic        instruction_ready;
    word_t       instruction;
    logic        data_ready;
    word_t       data_rdata;
    logic        instruction_valid;
    word_t       instruction_addr;
    logic        data_valid;
    logic        data_wr;
    word_t       data_addr;
    word_t       data_wdata;
    word_t       debug_wb_pc;
    logic        debug_wb_rf_wen;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;

    word_t       prog [0:PROG_WORDS-1];
    word_t       dmem [0:63];
    word_t       ifetch_offset;
    word_t       exp_pc [$];
    reg_addr_t   exp_reg [$];
    word_t       exp_val [$];
    logic        table_ready;
    int unsigned seed_value;

    pipeline_cpu uut (.*);

    bind pipeline_cpu pipeline_cpu_checker u_checker (.*);

    always #4 clk = ~clk;

    // both memories answer in the cycle of the request
    assign ifetch_offset = instruction_addr - `CPU_RESET_PC;
    assign instruction   = (ifetch_offset < word_t'(PROG_WORDS * 4)) ?
                           prog[ifetch_offset[6:2]] : `CPU_NOP;
    assign data_rdata    = dmem[data_addr[7:2]];

    // random ready on both buses
    initial
    begin
        seed_value = $urandom(SEED);
        forever
        begin
            @(posedge clk);
            instruction_ready <= ($urandom % 2) == 1;
            data_ready        <= ($urandom % 2) == 1;
        end
    end

    always @(posedge clk)
    begin
        if (data_valid && data_ready && data_wr)
            dmem[data_addr[7:2]] <= data_wdata;
    end

    function automatic word_t r_type(input logic [5:0] fn, input int rd, input int rs,
                                     input int rt);
        return {`CPU_OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input int rt, input int rs,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // a nonzero rd also queues the expected writeback entry
    task automatic add_instr(input int index, input word_t word, input int rd,
                             input word_t value);
        prog[index] = word;
        if (rd != 0)
        begin
            exp_pc.push_back(`CPU_RESET_PC + word_t'(index * 4));
            exp_reg.push_back(reg_addr_t'(rd));
            exp_val.push_back(value);
        end
    endtask

    task automatic load_table();
        for (int i = 0; i < PROG_WORDS; i++)
            prog[i] = `CPU_NOP;
        for (int i = 0; i < 64; i++)
            dmem[i] = ~word_t'(i * 4);
        // alu and immediates, forwarding from execute and memory access
        add_instr(0, i_type(`CPU_OP_LUI, 1, 0, 16'h1234), 1, 32'h12340000);
        add_instr(1, i_type(`CPU_OP_ORI, 1, 1, 16'h5678), 1, 32'h12345678);
        add_instr(2, i_type(`CPU_OP_ADDIU, 2, 0, 16'h0010), 2, 32'h00000010);
        add_instr(3, r_type(`CPU_FN_ADDU, 3, 1, 2), 3, 32'h12345688);
        add_instr(4, r_type(`CPU_FN_SUBU, 4, 3, 1), 4, 32'h00000010);
        add_instr(5, r_type(`CPU_FN_XOR, 5, 3, 1), 5, 32'h000000f0);
        add_instr(6, r_type(`CPU_FN_AND, 6, 1, 3), 6, 32'h12345608);
        add_instr(7, r_type(`CPU_FN_OR, 7, 4, 5), 7, 32'h000000f0);
        add_instr(8, r_type(`CPU_FN_SLT, 8, 4, 5), 8, 32'h00000001);
        add_instr(9, i_type(`CPU_OP_ADDIU, 9, 0, 16'hffff), 9, 32'hffffffff);
        add_instr(10, r_type(`CPU_FN_SLT, 10, 9, 0), 10, 32'h00000001);
        add_instr(11, i_type(`CPU_OP_ANDI, 11, 9, 16'h8001), 11, 32'h00008001);
        // store then load of the same word, dependent add stalls a cycle
        add_instr(12, i_type(`CPU_OP_SW, 1, 2, 16'h0000), 0, 32'h0);
        add_instr(13, i_type(`CPU_OP_LW, 12, 2, 16'h0000), 12, 32'h12345678);
        add_instr(14, r_type(`CPU_FN_ADDU, 13, 12, 2), 13, 32'h12345688);
        add_instr(15, i_type(`CPU_OP_ADDIU, 0, 0, 16'h0005), 0, 32'h0);
        add_instr(16, r_type(`CPU_FN_ADDU, 14, 0, 2), 14, 32'h00000010);
        // taken beq, untaken bne, taken bne; index 19 and 24 are squashed
        add_instr(17, i_type(`CPU_OP_BEQ, 2, 4, 16'h0002), 0, 32'h0);
        add_instr(18, i_type(`CPU_OP_ADDIU, 15, 0, 16'h0077), 15, 32'h00000077);
        add_instr(19, i_type(`CPU_OP_ADDIU, 16, 0, 16'h0099), 0, 32'h0);
        add_instr(20, i_type(`CPU_OP_BNE, 2, 4, 16'h0002), 0, 32'h0);
        add_instr(21, i_type(`CPU_OP_ADDIU, 17, 0, 16'h0011), 17, 32'h00000011);
        add_instr(22, i_type(`CPU_OP_BNE, 2, 5, 16'h0002), 0, 32'h0);
        add_instr(23, i_type(`CPU_OP_ADDIU, 18, 0, 16'h0022), 18, 32'h00000022);
        add_instr(24, i_type(`CPU_OP_ADDIU, 19, 0, 16'h0033), 0, 32'h0);
        // load of an untouched word returns the fill pattern
        add_instr(25, i_type(`CPU_OP_LW, 20, 2, 16'h0004), 20, 32'hffffffeb);
        add_instr(26, i_type(`CPU_OP_ADDIU, 21, 20, 16'h0001), 21, 32'hffffffec);
    endtask

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic report_value(input string name, input word_t got, input word_t want);
        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, want);
        abort_run();
    endtask

    task automatic wait_retire();
        do
            @(posedge clk);
        while (!debug_wb_rf_wen);
    endtask

    // a failed property in the bound checker ends the run
    always @(uut.u_checker.failures)
    begin
        if (uut.u_checker.failures != 0)
        begin
            $display("a bus or trace property in the bound checker failed");
            abort_run();
        end
    end

    initial
    begin
        table_ready       = 1'b0;
        clk               = 1'b0;
        rst_n             = 1'b0;
        instruction_ready = 1'b0;
        data_ready        = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        foreach (exp_pc[i])
        begin
            wait_retire();
            assert (debug_wb_pc == exp_pc[i])
            else report_value("debug_wb_pc", debug_wb_pc, exp_pc[i]);
            assert (debug_wb_rf_wnum == exp_reg[i])
            else report_value("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(exp_reg[i]));
            assert (debug_wb_rf_wdata == exp_val[i])
            else report_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[i]);
        end
        // the tail of the program is all nops
        repeat (TAIL_CYCLES)
        begin
            @(posedge clk);
            assert (!debug_wb_rf_wen)
            else report_value("debug_wb_rf_wen", word_t'(debug_wb_rf_wen), 32'h0);
        end
        $display("Verification passed");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        repeat (RESET_CYCLES + exp_pc.size() * CYCLES_PER_ENTRY + TAIL_CYCLES) @(posedge clk);
        $display("timeout: the writeback trace did not reach the end of the table in time");
        abort_run();
    end

endmodule

//--- dv/pipeline_cpu_checker.sv
`timescale 1ns/10ps

module pipeline_cpu_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               instruction_valid,
    input logic               instruction_ready,
    input cpu_pkg::word_t     instruction_addr,
    input logic               data_valid,
    input logic               data_ready,
    input logic               data_wr,
    input cpu_pkg::word_t     data_addr,
    input cpu_pkg::word_t     data_wdata,
    input logic               debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum
);

    // number of failed properties
    int unsigned failures = 0;

    // a stalled request keeps its address until ready
    ibus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        instruction_valid && !instruction_ready |=>
            instruction_valid && $stable(instruction_addr))
    else
    begin
        $error("instruction request changed while the instruction bus was stalled");
        failures++;
    end

    dbus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid && !data_ready |=>
            data_valid && $stable({data_wr, data_addr, data_wdata}))
    else
    begin
        $error("data request changed while the data bus was stalled");
        failures++;
    end

    trace_no_r0: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_wen |-> debug_wb_rf_wnum != '0)
    else
    begin
        $error("writeback trace reported a write to r0");
        failures++;
    end

    // sampled in the cycle that follows a reset edge
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !instruction_valid && !data_valid && !debug_wb_rf_wen)
    else
    begin
        $error("a valid output was high in the cycle after reset");
        failures++;
    end

endmodule

//--- design/pipeline_cpu.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pipeline_cpu (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instruction_ready,
    input  cpu_pkg::word_t     instruction,
    input  logic               data_ready,
    input  cpu_pkg::word_t     data_rdata,
    output logic               instruction_valid,
    output cpu_pkg::word_t     instruction_addr,
    output logic               data_valid,
    output logic               data_wr,
    output cpu_pkg::word_t     data_addr,
    output cpu_pkg::word_t     data_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    if_id_t    if_id_q;
    if_id_t    fetched;
    id_ex_t    id_ex_q;
    id_ex_t    decoded;
    ex_mem_t   ex_mem_q;
    ex_mem_t   exec_out;
    mem_wb_t   mem_wb_q;
    mem_wb_t   mem_out;
    fwd_src_t  ex_fwd;
    fwd_src_t  mem_fwd;
    dbus_req_t dbus;
    word_t     branch_target;
    logic      branch_taken;
    logic      load_use_stall;
    logic      fetch_ready;
    logic      mem_done;
    logic      bus_busy;
    logic      advance;

    // either bus waiting on ready freezes every stage
    assign bus_busy = (instruction_valid && !instruction_ready) || (data_valid && !data_ready);
    assign advance  = !bus_busy && mem_done && (fetch_ready || load_use_stall || branch_taken);

    fetch_unit u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .advance           (advance),
        .hold              (load_use_stall),
        .redirect          (branch_taken),
        .redirect_pc       (branch_target),
        .instruction_ready (instruction_ready),
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .instruction_addr  (instruction_addr),
        .fetched           (fetched),
        .fetch_ready       (fetch_ready)
    );

    decode_unit u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .decode_in      (if_id_q),
        .wb_in          (mem_wb_q),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .decoded        (decoded),
        .load_use_stall (load_use_stall)
    );

    execute_unit u_execute (
        .exec_in       (id_ex_q),
        .exec_out      (exec_out),
        .ex_fwd        (ex_fwd),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mem_access u_mem_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .mem_in     (ex_mem_q),
        .data_ready (data_ready),
        .data_rdata (data_rdata),
        .data_valid (data_valid),
        .dbus       (dbus),
        .mem_out    (mem_out),
        .mem_fwd    (mem_fwd),
        .mem_done   (mem_done)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            if_id_q  <= '{pc: '0, instr: `CPU_NOP};
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end
        else if (advance)
        begin
            // delay slot moves on, the word behind it is squashed
            if (branch_taken)
                if_id_q <= '{pc: '0, instr: `CPU_NOP};
            else if (!load_use_stall)
                if_id_q <= fetched;
            id_ex_q  <= load_use_stall ? id_ex_t'('0) : decoded;
            ex_mem_q <= exec_out;
            mem_wb_q <= mem_out;
        end
    end

    assign data_wr    = dbus.wr;
    assign data_addr  = dbus.addr;
    assign data_wdata = dbus.wdata;

    // one trace pulse per retired write, on the cycle it leaves writeback
    assign debug_wb_pc       = mem_wb_q.pc;
    assign debug_wb_rf_wen   = mem_wb_q.wen && advance;
    assign debug_wb_rf_wnum  = mem_wb_q.dest;
    assign debug_wb_rf_wdata = mem_wb_q.wdata;

endmodule

//--- design/mem_access.sv
`timescale 1ns/10ps

module mem_access (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  cpu_pkg::ex_mem_t    mem_in,
    input  logic                data_ready,
    input  cpu_pkg::word_t      data_rdata,
    output logic                data_valid,
    output cpu_pkg::dbus_req_t  dbus,
    output cpu_pkg::mem_wb_t    mem_out,
    output cpu_pkg::fwd_src_t   mem_fwd,
    output logic                mem_done
);
    import cpu_pkg::*;

    word_t q_word;
    word_t load_word;
    logic  q_full;
    logic  access;
    logic  dbus_xfer;

    assign access    = mem_in.load || mem_in.store;
    // a finished transfer is not repeated while the pipeline is frozen
    assign data_valid = access && !q_full;
    assign dbus_xfer = data_valid && data_ready;
    assign mem_done  = !access || q_full || dbus_xfer;

    assign dbus = '{wr: mem_in.store, addr: mem_in.result, wdata: mem_in.store_data};

    assign load_word = q_full ? q_word : data_rdata;

    assign mem_out = '{
        pc:    mem_in.pc,
        wen:   mem_in.wen,
        dest:  mem_in.dest,
        wdata: mem_in.load ? load_word : mem_in.result
    };

    assign mem_fwd = '{wen: mem_out.wen, dest: mem_out.dest, value: mem_out.wdata,
                       load: mem_in.load};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            q_full <= 1'b0;
        else if (advance)
            q_full <= 1'b0;
        else if (dbus_xfer)
            q_full <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (dbus_xfer)
            q_word <= data_rdata;
    end

endmodule

//--- design/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  cpu_pkg::id_ex_t   exec_in,
    output cpu_pkg::ex_mem_t  exec_out,
    output cpu_pkg::fwd_src_t ex_fwd,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target
);
    import cpu_pkg::*;

    word_t result;
    logic  operands_equal;

    // loads and stores use ALU_ADD with the offset in op_b
    always_comb
    begin
        case (exec_in.alu_op)
            ALU_ADD: result = exec_in.op_a + exec_in.op_b;
            ALU_SUB: result = exec_in.op_a - exec_in.op_b;
            ALU_AND: result = exec_in.op_a & exec_in.op_b;
            ALU_OR:  result = exec_in.op_a | exec_in.op_b;
            ALU_XOR: result = exec_in.op_a ^ exec_in.op_b;
            ALU_SLT: result = word_t'($signed(exec_in.op_a) < $signed(exec_in.op_b));
            ALU_LUI: result = {exec_in.op_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign operands_equal = (exec_in.op_a == exec_in.op_b);
    assign branch_taken   = exec_in.valid && exec_in.branch && (operands_equal != exec_in.bne);
    assign branch_target  = exec_in.target;

    assign exec_out = '{
        result:     result,
        store_data: exec_in.store_data,
        dest:       exec_in.dest,
        wen:        exec_in.valid && exec_in.wen,
        load:       exec_in.valid && exec_in.load,
        store:      exec_in.valid && exec_in.store,
        pc:         exec_in.pc
    };

    assign ex_fwd = '{
        wen:   exec_out.wen,
        dest:  exec_out.dest,
        value: result,
        load:  exec_out.load
    };

endmodule

//--- design/decode_unit.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decode_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::if_id_t   decode_in,
    input  cpu_pkg::mem_wb_t  wb_in,
    input  cpu_pkg::fwd_src_t ex_fwd,
    input  cpu_pkg::fwd_src_t mem_fwd,
    output cpu_pkg::id_ex_t   decoded,
    output logic              load_use_stall
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    reg_addr_t  rd_addr;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      pc_plus4;
    word_t      rs_rf;
    word_t      rt_rf;
    word_t      rs_value;
    word_t      rt_value;
    logic       uses_rt;

    assign opcode   = decode_in.instr[31:26];
    assign rs_addr  = decode_in.instr[25:21];
    assign rt_addr  = decode_in.instr[20:16];
    assign rd_addr  = decode_in.instr[15:11];
    assign funct    = decode_in.instr[5:0];
    assign imm_sext = {{16{decode_in.instr[15]}}, decode_in.instr[15:0]};
    assign imm_zext = {16'h0000, decode_in.instr[15:0]};
    assign pc_plus4 = decode_in.pc + word_t'(4);

    // rt is a source for R-type, stores and branches
    assign uses_rt = (opcode == `CPU_OP_SPECIAL) || (opcode == `CPU_OP_SW) ||
                     (opcode == `CPU_OP_BEQ) || (opcode == `CPU_OP_BNE);

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb_in   (wb_in),
        .rs_data (rs_rf),
        .rt_data (rt_rf)
    );

    hazard_unit u_hazard_unit (
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .uses_rt        (uses_rt),
        .rs_rf          (rs_rf),
        .rt_rf          (rt_rf),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .load_use_stall (load_use_stall)
    );

    always_comb
    begin
        decoded            = '0;
        decoded.valid      = |decode_in.instr;
        decoded.pc         = decode_in.pc;
        decoded.op_a       = rs_value;
        decoded.op_b       = rt_value;
        decoded.store_data = rt_value;
        decoded.dest       = rt_addr;
        decoded.target     = pc_plus4 + {imm_sext[29:0], 2'b00};
        decoded.alu_op     = ALU_ADD;
        case (opcode)
            `CPU_OP_SPECIAL:
            begin
                decoded.dest = rd_addr;
                decoded.wen  = 1'b1;
                case (funct)
                    `CPU_FN_ADDU: decoded.alu_op = ALU_ADD;
                    `CPU_FN_SUBU: decoded.alu_op = ALU_SUB;
                    `CPU_FN_AND:  decoded.alu_op = ALU_AND;
                    `CPU_FN_OR:   decoded.alu_op = ALU_OR;
                    `CPU_FN_XOR:  decoded.alu_op = ALU_XOR;
                    `CPU_FN_SLT:  decoded.alu_op = ALU_SLT;
                    default:      decoded.wen    = 1'b0;
                endcase
            end
            `CPU_OP_ADDIU:
            begin
                decoded.op_b = imm_sext;
                decoded.wen  = 1'b1;
            end
            `CPU_OP_ANDI:
            begin
                decoded.alu_op = ALU_AND;
                decoded.op_b   = imm_zext;
                decoded.wen    = 1'b1;
            end
            `CPU_OP_ORI:
            begin
                decoded.alu_op = ALU_OR;
                decoded.op_b   = imm_zext;
                decoded.wen    = 1'b1;
            end
            `CPU_OP_LUI:
            begin
                decoded.alu_op = ALU_LUI;
                decoded.op_b   = imm_zext;
                decoded.wen    = 1'b1;
            end
            `CPU_OP_LW:
            begin
                decoded.op_b = imm_sext;
                decoded.load = 1'b1;
                decoded.wen  = 1'b1;
            end
            `CPU_OP_SW:
            begin
                decoded.op_b  = imm_sext;
                decoded.store = 1'b1;
            end
            `CPU_OP_BEQ: decoded.branch = 1'b1;
            `CPU_OP_BNE:
            begin
                decoded.branch = 1'b1;
                decoded.bne    = 1'b1;
            end
            default: decoded.wen = 1'b0;
        endcase
        // writes to r0 are dropped here so they never reach the trace
        if (decoded.dest == '0)
            decoded.wen = 1'b0;
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               uses_rt,
    input  cpu_pkg::word_t     rs_rf,
    input  cpu_pkg::word_t     rt_rf,
    input  cpu_pkg::fwd_src_t  ex_fwd,
    input  cpu_pkg::fwd_src_t  mem_fwd,
    output cpu_pkg::word_t     rs_value,
    output cpu_pkg::word_t     rt_value,
    output logic               load_use_stall
);
    import cpu_pkg::*;

    logic ex_load_rs;
    logic ex_load_rt;

    // later stage overrides earlier, execute wins unless it is a load
    function automatic word_t newest(input reg_addr_t addr, input word_t rf_value,
                                     input fwd_src_t ex_src, input fwd_src_t mem_src);
        word_t value;
        value = rf_value;
        if (addr != '0 && mem_src.wen && mem_src.dest == addr)
            value = mem_src.value;
        if (addr != '0 && ex_src.wen && !ex_src.load && ex_src.dest == addr)
            value = ex_src.value;
        return value;
    endfunction

    assign rs_value = newest(rs_addr, rs_rf, ex_fwd, mem_fwd);
    assign rt_value = newest(rt_addr, rt_rf, ex_fwd, mem_fwd);

    // load data only exists once the load reaches memory access
    assign ex_load_rs = ex_fwd.wen && ex_fwd.load && rs_addr != '0 &&
                        ex_fwd.dest == rs_addr;
    assign ex_load_rt = ex_fwd.wen && ex_fwd.load && uses_rt && rt_addr != '0 &&
                        ex_fwd.dest == rt_addr;

    assign load_use_stall = ex_load_rs || ex_load_rt;

endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::mem_wb_t   wb_in,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);
    import cpu_pkg::*;

    word_t regs [0:31];

    // write-first, so decode sees the value retiring this cycle
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb_in.wen && wb_in.dest == rs_addr) ? wb_in.wdata : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb_in.wen && wb_in.dest == rt_addr) ? wb_in.wdata : regs[rt_addr];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_in.wen && wb_in.dest != '0)
        begin
            regs[wb_in.dest] <= wb_in.wdata;
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,
    input  logic            hold,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_pc,
    input  logic            instruction_ready,
    input  cpu_pkg::word_t  instruction,
    output logic            instruction_valid,
    output cpu_pkg::word_t  instruction_addr,
    output cpu_pkg::if_id_t fetched,
    output logic            fetch_ready
);
    import cpu_pkg::*;

    word_t pc;
    word_t q_word;
    logic  q_full;
    logic  running;
    logic  ibus_xfer;

    // no request while the word for pc is already queued
    assign instruction_valid = running && !q_full && !hold && !redirect;
    assign instruction_addr  = pc;
    assign ibus_xfer         = instruction_valid && instruction_ready;
    assign fetch_ready       = q_full || ibus_xfer;

    assign fetched = '{pc: pc, instr: q_full ? q_word : instruction};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc      <= `CPU_RESET_PC;
            q_full  <= 1'b0;
            running <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (advance && redirect)
            begin
                // word after the delay slot is dropped
                pc     <= redirect_pc;
                q_full <= 1'b0;
            end
            else if (advance && !hold && fetch_ready)
            begin
                pc     <= pc + word_t'(4);
                q_full <= 1'b0;
            end
            else if (ibus_xfer)
            begin
                q_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ibus_xfer)
            q_word <= instruction;
    end

endmodule

//--- design/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        reg_addr_t dest;
        logic      wen;
        logic      load;
        logic      store;
        logic      branch;
        logic      bne;
        word_t     target;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      wen;
        logic      load;
        logic      store;
        word_t     pc;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t dest;
        word_t     wdata;
    } mem_wb_t;

    typedef struct packed {
        logic  wr;
        word_t addr;
        word_t wdata;
    } dbus_req_t;

    // one stage's pending register write, seen by the hazard unit
    typedef struct packed {
        logic      wen;
        reg_addr_t dest;
        word_t     value;
        logic      load;
    } fwd_src_t;

endpackage

//--- design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_RESET_PC    32'hbfc00000
`define CPU_NOP         32'h00000000

// primary opcodes
`define CPU_OP_SPECIAL  6'h00
`define CPU_OP_BEQ      6'h04
`define CPU_OP_BNE      6'h05
`define CPU_OP_ADDIU    6'h09
`define CPU_OP_ANDI     6'h0c
`define CPU_OP_ORI      6'h0d
`define CPU_OP_LUI      6'h0f
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b

// function codes under SPECIAL
`define CPU_FN_ADDU     6'h21
`define CPU_FN_SUBU     6'h23
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_XOR      6'h26
`define CPU_FN_SLT      6'h2a

`endif
